// ==== verilog/fifo_pkg.sv ====
package fifo_pkg;

   // two-bit occupancy state code.
   typedef enum logic [1:0] {
      EMPTY       = 2'b00,
      GOING_FULL  = 2'b01,
      FULL        = 2'b11,
      GOING_EMPTY = 2'b10
   } fifo_state_e;

   // one fifo entry.
   typedef logic [7:0] data_t;

   // read and write pointer at the default depth of four.
   typedef logic [1:0] ptr_t;

endpackage

// ==== verilog/credit_pkg.sv ====
package credit_pkg;
   import fifo_pkg::*;

   // upstream push channel.
   typedef struct packed {
      logic  valid;
      data_t data;
   } push_req_t;

   // return channel toward the sender.
   typedef struct packed {
      logic credit;   // one-cycle credit return.
      logic overflow; // sticky, push seen with no credit out.
   } credit_rsp_t;

endpackage

// ==== verilog/fifo_fsm_logic.sv ====
module fifo_fsm_logic import fifo_pkg::*; #(
   parameter int PTR_W = 2
) (
   input  fifo_state_e      state,
   input  logic [PTR_W-1:0] read_ptr,
   input  logic [PTR_W-1:0] write_ptr,
   input  logic             add_fifo,
   input  logic             pop_fifo,
   input  logic             curr_empty,
   input  logic             curr_full,
   output fifo_state_e      next_state,
   output logic             fifo_empty,
   output logic             fifo_full,
   output logic             read_ctr_en,
   output logic             write_ctr_en,
   output logic             read_ctr_rst,
   output logic             write_ctr_rst,
   output logic             err
);

   logic [PTR_W-1:0] read_ptr_nxt;
   logic [PTR_W-1:0] write_ptr_nxt;
   logic             ptr_meet;

   // counter enables.
   always_comb begin
      read_ctr_en  = 1'b0;
      write_ctr_en = 1'b0;
      case (state)
         EMPTY: begin
            write_ctr_en = add_fifo; // pop ignored.
         end
         FULL: begin
            read_ctr_en = pop_fifo; // push ignored.
         end
         GOING_FULL, GOING_EMPTY: begin
            read_ctr_en  = pop_fifo & ~curr_empty;
            write_ctr_en = add_fifo & ~curr_full;
         end
         default: begin
            read_ctr_en  = 1'b0;
            write_ctr_en = 1'b0;
         end
      endcase
   end

   // pointers after this cycle, equal means empty or full.
   assign read_ptr_nxt  = read_ptr + PTR_W'(read_ctr_en);
   assign write_ptr_nxt = write_ptr + PTR_W'(write_ctr_en);
   assign ptr_meet      = (read_ptr_nxt == write_ptr_nxt);

   always_comb begin
      next_state    = state;
      fifo_empty    = 1'b0;
      fifo_full     = 1'b0;
      read_ctr_rst  = 1'b0;
      write_ctr_rst = 1'b0;
      err           = 1'b0;
      case (state)
         EMPTY: begin
            fifo_empty = ~write_ctr_en;
            next_state = write_ctr_en ? GOING_FULL : EMPTY;
         end
         FULL: begin
            fifo_full  = ~read_ctr_en;
            next_state = read_ctr_en ? GOING_EMPTY : FULL;
         end
         GOING_FULL, GOING_EMPTY: begin
            fifo_full  = ptr_meet & write_ctr_en & ~read_ctr_en;
            fifo_empty = ptr_meet & read_ctr_en & ~write_ctr_en;
            if (fifo_full) begin
               next_state = FULL;
            end else if (fifo_empty) begin
               next_state = EMPTY;
            end else if (write_ctr_en & ~read_ctr_en) begin
               next_state = GOING_FULL;
            end else if (read_ctr_en & ~write_ctr_en) begin
               next_state = GOING_EMPTY;
            end
         end
         default: begin
            // bad code, clear both counters and restart empty.
            err           = 1'b1;
            read_ctr_rst  = 1'b1;
            write_ctr_rst = 1'b1;
            fifo_empty    = 1'b1;
            next_state    = EMPTY;
         end
      endcase
   end

endmodule

// ==== verilog/fifo_ptr_ctr.sv ====
module fifo_ptr_ctr #(
   parameter int PTR_W = 2
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             en,
   input  logic             clr,
   output logic [PTR_W-1:0] ptr
);

   // wraps at 2**PTR_W on its own.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ptr <= '0;
      end else if (clr) begin
         ptr <= '0; // clear wins over en.
      end else if (en) begin
         ptr <= ptr + 1'b1;
      end
   end

endmodule

// ==== verilog/fifo_storage.sv ====
module fifo_storage import fifo_pkg::*; #(
   parameter int PTR_W = 2
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             wr_en,
   input  logic [PTR_W-1:0] wr_ptr,
   input  data_t            wr_data,
   input  logic [PTR_W-1:0] rd_ptr,
   output data_t            rd_data
);

   localparam int DEPTH = 1 << PTR_W;

   data_t mem [DEPTH];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else if (wr_en) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   // head of queue, no read latency.
   assign rd_data = mem[rd_ptr];

endmodule

// ==== verilog/fifo_ctrl.sv ====
module fifo_ctrl import fifo_pkg::*; #(
   parameter int PTR_W = 2
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             add_fifo,
   input  logic             pop,
   output logic             pop_accept,
   output logic             wr_en,
   output logic [PTR_W-1:0] write_ptr,
   output logic [PTR_W-1:0] read_ptr,
   output logic             empty,
   output logic             full,
   output logic             err
);

   fifo_state_e state;
   fifo_state_e next_state;
   logic        curr_empty;
   logic        curr_full;
   logic        fifo_empty;
   logic        fifo_full;
   logic        read_ctr_en;
   logic        write_ctr_en;
   logic        read_ctr_rst;
   logic        write_ctr_rst;
   logic        err_now;

   fifo_fsm_logic #(.PTR_W(PTR_W)) u_fsm (
      .state         (state),
      .read_ptr      (read_ptr),
      .write_ptr     (write_ptr),
      .add_fifo      (add_fifo),
      .pop_fifo      (pop),
      .curr_empty    (curr_empty),
      .curr_full     (curr_full),
      .next_state    (next_state),
      .fifo_empty    (fifo_empty),
      .fifo_full     (fifo_full),
      .read_ctr_en   (read_ctr_en),
      .write_ctr_en  (write_ctr_en),
      .read_ctr_rst  (read_ctr_rst),
      .write_ctr_rst (write_ctr_rst),
      .err           (err_now)
   );

   fifo_ptr_ctr #(.PTR_W(PTR_W)) u_wr_ctr (
      .clk   (clk),
      .rst_n (rst_n),
      .en    (write_ctr_en),
      .clr   (write_ctr_rst),
      .ptr   (write_ptr)
   );

   fifo_ptr_ctr #(.PTR_W(PTR_W)) u_rd_ctr (
      .clk   (clk),
      .rst_n (rst_n),
      .en    (read_ctr_en),
      .clr   (read_ctr_rst),
      .ptr   (read_ptr)
   );

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= EMPTY;
         curr_empty <= 1'b1;
         curr_full  <= 1'b0;
         err        <= 1'b0;
      end else begin
         state      <= next_state;
         curr_empty <= fifo_empty;
         curr_full  <= fifo_full;
         err        <= err | err_now; // held until reset.
      end
   end

   assign empty      = curr_empty;
   assign full       = curr_full;
   assign wr_en      = write_ctr_en;
   assign pop_accept = read_ctr_en;

endmodule

// ==== verilog/credit_port.sv ====
module credit_port import fifo_pkg::*, credit_pkg::*; #(
   parameter int PTR_W = 2
) (
   input  logic        clk,
   input  logic        rst_n,
   input  push_req_t   push,
   input  logic        pop_accept,
   output logic        add_fifo,
   output credit_rsp_t credit_ret,
   output data_t       wr_data
);

   localparam int DEPTH = 1 << PTR_W;

   logic [PTR_W:0] credits; // credits held by the sender.
   logic           has_credit;
   logic           push_ok;

   assign has_credit = (credits != '0);
   assign push_ok    = push.valid & has_credit;

   // sender counts a returned credit at the edge ending the pulse.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         credits <= DEPTH[PTR_W:0];
      end else begin
         case ({push_ok, credit_ret.credit})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         credit_ret <= '0;
      end else begin
         credit_ret.credit <= pop_accept; // one per popped entry.
         if (push.valid && !has_credit) begin
            credit_ret.overflow <= 1'b1;
         end
      end
   end

   // pushes without a credit are dropped here.
   assign add_fifo = push_ok;
   assign wr_data  = push.data;

endmodule

// ==== verilog/fifo_credit_top.sv ====
module fifo_credit_top import fifo_pkg::*, credit_pkg::*; #(
   parameter int PTR_W = $bits(ptr_t)
) (
   input  logic        clk,
   input  logic        rst_n,
   input  push_req_t   push,
   output credit_rsp_t credit_ret,
   input  logic        pop,
   output data_t       rd_data,
   output logic        empty,
   output logic        full,
   output logic        err
);

   logic             add_fifo;
   logic             pop_accept;
   logic             wr_en;
   logic [PTR_W-1:0] write_ptr;
   logic [PTR_W-1:0] read_ptr;
   data_t            wr_data;

   credit_port #(.PTR_W(PTR_W)) u_credit (
      .clk        (clk),
      .rst_n      (rst_n),
      .push       (push),
      .pop_accept (pop_accept),
      .add_fifo   (add_fifo),
      .credit_ret (credit_ret),
      .wr_data    (wr_data)
   );

   fifo_ctrl #(.PTR_W(PTR_W)) u_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .add_fifo   (add_fifo),
      .pop        (pop),
      .pop_accept (pop_accept),
      .wr_en      (wr_en),
      .write_ptr  (write_ptr),
      .read_ptr   (read_ptr),
      .empty      (empty),
      .full       (full),
      .err        (err)
   );

   fifo_storage #(.PTR_W(PTR_W)) u_mem (
      .clk     (clk),
      .rst_n   (rst_n),
      .wr_en   (wr_en),
      .wr_ptr  (write_ptr),
      .wr_data (wr_data),
      .rd_ptr  (read_ptr),
      .rd_data (rd_data)
   );

endmodule

// ==== bench/fifo_credit_checker.sv ====
module fifo_credit_checker import fifo_pkg::*; (
   input logic        clk,
   input logic        rst_n,
   input fifo_state_e state,
   input logic        empty,
   input logic        full,
   input logic        wr_en,
   input logic        pop_accept,
   input logic        err
);

   int unsigned fail_count = 0; // read by the testbench at the end.

   state_legal: assert property (@(posedge clk) disable iff (!rst_n)
      !$isunknown(state) && (state inside {EMPTY, GOING_FULL, FULL, GOING_EMPTY}))
   else begin
      $error("state register holds an illegal code");
      fail_count++;
   end

   flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
      !(empty && full))
   else begin
      $error("empty and full set together");
      fail_count++;
   end

   // a full fifo only takes a write alongside a pop.
   no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n)
      (full && !pop_accept) |-> !wr_en)
   else begin
      $error("write enabled while full without a pop");
      fail_count++;
   end

   err_low: assert property (@(posedge clk) disable iff (!rst_n) !err)
   else begin
      $error("controller raised err");
      fail_count++;
   end

endmodule

bind fifo_ctrl fifo_credit_checker u_checker (
   .clk        (clk),
   .rst_n      (rst_n),
   .state      (state),
   .empty      (empty),
   .full       (full),
   .wr_en      (wr_en),
   .pop_accept (pop_accept),
   .err        (err)
);

// ==== bench/tb_fifo_credit.sv ====
module tb_fifo_credit
   import fifo_pkg::*, credit_pkg::*;
();

   localparam int PTR_W      = 2;
   localparam int DEPTH      = 1 << PTR_W;
   localparam int RST_CYCLES = 3;
   localparam int N_ROWS     = 25;
   localparam int MAX_CYCLES = N_ROWS + RST_CYCLES + 20;

   // one cycle of stimulus and the outputs expected after it is taken.
   typedef struct packed {
      logic  push_v;
      data_t push_d;
      logic  pop;
      logic  exp_empty;
      logic  exp_full;
      data_t exp_data;
      logic  exp_credit;
      logic  exp_ovf;
   } row_t;

   logic        clk;
   logic        rst_n;
   push_req_t   push;
   logic        pop;
   credit_rsp_t credit_ret;
   data_t       rd_data;
   logic        empty;
   logic        full;
   logic        err;

   row_t  table_q [N_ROWS];
   int    n_rows = 0;
   int    row_idx = 0;
   int    mismatches = 0;
   int    cycle_cnt = 0;
   int    seed = 78;
   data_t model_q [$]; // entries in push order.
   int    model_credits = DEPTH;

   fifo_credit_top #(.PTR_W(PTR_W)) dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .push       (push),
      .credit_ret (credit_ret),
      .pop        (pop),
      .rd_data    (rd_data),
      .empty      (empty),
      .full       (full),
      .err        (err)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic stop_on_failure();
      $display("TEST FAIL");
      $fatal(1, "stopped at first failure");
   endtask

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
         stop_on_failure();
      end
   end

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERROR: %s row %0d got 0x%0h expected 0x%0h", name, row_idx, got, exp);
         stop_on_failure();
      end
   endtask

   task automatic check_data(input string name, input data_t got, input data_t exp);
      if (got !== exp) begin
         $display("ERROR: %s row %0d got 0x%0h expected 0x%0h", name, row_idx, got, exp);
         stop_on_failure();
      end
   endtask

   task automatic check_credit(input string name, input credit_rsp_t got,
                               input credit_rsp_t exp);
      if (got !== exp) begin
         $display("ERROR: %s row %0d got 0x%0h expected 0x%0h", name, row_idx, got, exp);
         stop_on_failure();
      end
   endtask

   // expected flags per row and head entry from the queue model.
   task automatic add_row(input logic push_v, input logic pop_v, input logic e_empty,
                          input logic e_full, input logic e_credit, input logic e_ovf);
      row_t  r;
      data_t d;
      logic  pop_ok;
      logic  push_ok;
      d       = push_v ? data_t'($random(seed)) : '0;
      pop_ok  = pop_v && (model_q.size() > 0);
      push_ok = push_v && (model_credits > 0) && (model_q.size() < DEPTH);
      if (pop_ok) begin
         void'(model_q.pop_front());
         model_credits++; // returned by the pulse.
      end
      if (push_ok) begin
         model_q.push_back(d);
         model_credits--;
      end
      r.push_v     = push_v;
      r.push_d     = d;
      r.pop        = pop_v;
      r.exp_empty  = e_empty;
      r.exp_full   = e_full;
      r.exp_data   = (model_q.size() > 0) ? model_q[0] : '0;
      r.exp_credit = e_credit;
      r.exp_ovf    = e_ovf;
      table_q[n_rows] = r;
      n_rows++;
   endtask

   task automatic check_row(input row_t r);
      credit_rsp_t exp_rsp;
      exp_rsp.credit   = r.exp_credit;
      exp_rsp.overflow = r.exp_ovf;
      check_flag("empty", empty, r.exp_empty);
      check_flag("full", full, r.exp_full);
      check_flag("err", err, 1'b0);
      check_credit("credit_ret", credit_ret, exp_rsp);
      if (!r.exp_empty) begin
         check_data("rd_data", rd_data, r.exp_data);
      end
   endtask

   task automatic build_table();
      add_row(0, 0, 1, 0, 0, 0); // reset values.
      add_row(1, 0, 0, 0, 0, 0); // fill.
      add_row(1, 0, 0, 0, 0, 0);
      add_row(1, 0, 0, 0, 0, 0);
      add_row(1, 0, 0, 1, 0, 0);
      add_row(0, 1, 0, 0, 1, 0); // drain in order.
      add_row(0, 1, 0, 0, 1, 0);
      add_row(0, 1, 0, 0, 1, 0);
      add_row(0, 1, 1, 0, 1, 0);
      add_row(0, 1, 1, 0, 0, 0); // pop while empty.
      add_row(0, 0, 1, 0, 0, 0);
      add_row(1, 0, 0, 0, 0, 0); // half full.
      add_row(1, 0, 0, 0, 0, 0);
      add_row(1, 1, 0, 0, 1, 0); // push and pop together.
      add_row(1, 1, 0, 0, 1, 0);
      add_row(0, 0, 0, 0, 0, 0);
      add_row(1, 0, 0, 0, 0, 0);
      add_row(1, 0, 0, 1, 0, 0);
      add_row(1, 0, 0, 1, 0, 1); // no credit left.
      add_row(0, 0, 0, 1, 0, 1);
      add_row(0, 1, 0, 0, 1, 1);
      add_row(0, 1, 0, 0, 1, 1);
      add_row(0, 1, 0, 0, 1, 1);
      add_row(0, 1, 1, 0, 1, 1);
      add_row(0, 0, 1, 0, 0, 1);
   endtask

   initial begin
      rst_n = 1'b0;
      push  = '0;
      pop   = 1'b0;
      build_table();
      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      // row i is driven while row i-1 is checked.
      for (int i = 0; i <= n_rows; i++) begin
         @(posedge clk);
         if (i < n_rows) begin
            push.valid <= table_q[i].push_v;
            push.data  <= table_q[i].push_d;
            pop        <= table_q[i].pop;
         end else begin
            push.valid <= 1'b0;
            pop        <= 1'b0;
         end
         @(negedge clk);
         if (i > 0) begin
            row_idx = i - 1;
            check_row(table_q[i - 1]);
         end
      end
      if (dut.u_ctrl.u_checker.fail_count != 0) begin
         $display("assertions in the controller checker failed %0d times",
                  dut.u_ctrl.u_checker.fail_count);
         mismatches++;
      end
      if (mismatches == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// ==== all.f ====
verilog/fifo_pkg.sv
verilog/credit_pkg.sv
verilog/fifo_fsm_logic.sv
verilog/fifo_ptr_ctr.sv
verilog/fifo_storage.sv
verilog/fifo_ctrl.sv
verilog/credit_port.sv
verilog/fifo_credit_top.sv
bench/fifo_credit_checker.sv
bench/tb_fifo_credit.sv

// ==== Bender.yml ====
package:
  name: fifo_credit

sources:
  - files:
      - verilog/fifo_pkg.sv
      - verilog/credit_pkg.sv
      - verilog/fifo_fsm_logic.sv
      - verilog/fifo_ptr_ctr.sv
      - verilog/fifo_storage.sv
      - verilog/fifo_ctrl.sv
      - verilog/credit_port.sv
      - verilog/fifo_credit_top.sv
  - target: test
    files:
      - bench/fifo_credit_checker.sv
      - bench/tb_fifo_credit.sv
